//--- logic/rotPkg.sv
// Shared widths, pipeline latencies and payload types for the phase rotator
package rotPkg;

   // --------------------
   // Widths
   // --------------------
   localparam int ROT_BITS   = 12;   // I/Q sample width
   localparam int COEF_BITS  = 12;   // Signed cos/sin, unity at 1024
   localparam int PHASE_BITS = 5;    // 32 steps around the circle
   localparam int SEL_BITS   = 5;    // Select word riding with the data

   // --------------------
   // Latencies and scaling
   // --------------------
   localparam int ROT_LATENCY = 3;   // Table lookup plus two multiply stages
   localparam int PROD_SHIFT  = 11;  // Unity coef is 2^10, so output lands at half scale

   // --------------------
   // Payload types
   // --------------------
   typedef logic signed [ROT_BITS-1:0]   sample;
   typedef logic signed [COEF_BITS-1:0]  coef;
   typedef logic        [PHASE_BITS-1:0] phaseIdx;   // Unsigned, wraps mod 2pi

   // Sample pair, I in the upper half
   typedef struct packed {
      sample i;
      sample q;
   } iqPair;

   // Strobes and select word that follow a sample down the pipe
   typedef struct packed {
      logic                symEn;
      logic                sym2xEn;
      logic [SEL_BITS-1:0] sel;
   } ctrlBundle;

endpackage

//--- logic/delayLine.sv
// Resettable register chain for any packed payload type
`timescale 1ns/10ps

module delayLine #(
   parameter type payloadT = logic,
   parameter int  DEPTH    = 1          // Number of register stages, at least 1
) (
   input  logic    clk,
   input  logic    reset,
   input  payloadT din,
   output payloadT dout
);

   payloadT stages [DEPTH];   // stages[0] is nearest the input

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int k = 0; k < DEPTH; k++) begin
            stages[k] <= '0;           // Flush, strobes come out low
         end
      end else begin
         stages[0] <= din;
         for (int k = 1; k < DEPTH; k++) begin
            stages[k] <= stages[k-1];   // Shift one stage per clock
         end
      end
   end

   assign dout = stages[DEPTH-1];   // Oldest entry

endmodule

//--- logic/phaseCoefRom.sv
// Registered 32-entry lookup from phase index to cos/sin coefficients
`timescale 1ns/10ps

module phaseCoefRom (
   input  logic            clk,
   input  logic            reset,
   input  rotPkg::phaseIdx angle,
   output rotPkg::coef     cosVal,
   output rotPkg::coef     sinVal
);

   rotPkg::coef cosNext;
   rotPkg::coef sinNext;

   // Round(cos * 1024), round(sin * 1024) at k * 2pi/32
   always_comb begin
      case (angle)
         0:  {cosNext, sinNext} = {rotPkg::coef'(1024),  rotPkg::coef'(0)};
         1:  {cosNext, sinNext} = {rotPkg::coef'(1004),  rotPkg::coef'(200)};
         2:  {cosNext, sinNext} = {rotPkg::coef'(946),   rotPkg::coef'(392)};
         3:  {cosNext, sinNext} = {rotPkg::coef'(851),   rotPkg::coef'(569)};
         4:  {cosNext, sinNext} = {rotPkg::coef'(724),   rotPkg::coef'(724)};   // pi/4
         5:  {cosNext, sinNext} = {rotPkg::coef'(569),   rotPkg::coef'(851)};
         6:  {cosNext, sinNext} = {rotPkg::coef'(392),   rotPkg::coef'(946)};
         7:  {cosNext, sinNext} = {rotPkg::coef'(200),   rotPkg::coef'(1004)};
         // Second quadrant
         8:  {cosNext, sinNext} = {rotPkg::coef'(0),     rotPkg::coef'(1024)};  // pi/2
         9:  {cosNext, sinNext} = {rotPkg::coef'(-200),  rotPkg::coef'(1004)};
         10: {cosNext, sinNext} = {rotPkg::coef'(-392),  rotPkg::coef'(946)};
         11: {cosNext, sinNext} = {rotPkg::coef'(-569),  rotPkg::coef'(851)};
         12: {cosNext, sinNext} = {rotPkg::coef'(-724),  rotPkg::coef'(724)};
         13: {cosNext, sinNext} = {rotPkg::coef'(-851),  rotPkg::coef'(569)};
         14: {cosNext, sinNext} = {rotPkg::coef'(-946),  rotPkg::coef'(392)};
         15: {cosNext, sinNext} = {rotPkg::coef'(-1004), rotPkg::coef'(200)};
         // Third quadrant
         16: {cosNext, sinNext} = {rotPkg::coef'(-1024), rotPkg::coef'(0)};    // pi
         17: {cosNext, sinNext} = {rotPkg::coef'(-1004), rotPkg::coef'(-200)};
         18: {cosNext, sinNext} = {rotPkg::coef'(-946),  rotPkg::coef'(-392)};
         19: {cosNext, sinNext} = {rotPkg::coef'(-851),  rotPkg::coef'(-569)};
         20: {cosNext, sinNext} = {rotPkg::coef'(-724),  rotPkg::coef'(-724)};
         21: {cosNext, sinNext} = {rotPkg::coef'(-569),  rotPkg::coef'(-851)};
         22: {cosNext, sinNext} = {rotPkg::coef'(-392),  rotPkg::coef'(-946)};
         23: {cosNext, sinNext} = {rotPkg::coef'(-200),  rotPkg::coef'(-1004)};
         // Fourth quadrant
         24: {cosNext, sinNext} = {rotPkg::coef'(0),     rotPkg::coef'(-1024)}; // 3pi/2
         25: {cosNext, sinNext} = {rotPkg::coef'(200),   rotPkg::coef'(-1004)};
         26: {cosNext, sinNext} = {rotPkg::coef'(392),   rotPkg::coef'(-946)};
         27: {cosNext, sinNext} = {rotPkg::coef'(569),   rotPkg::coef'(-851)};
         28: {cosNext, sinNext} = {rotPkg::coef'(724),   rotPkg::coef'(-724)};
         29: {cosNext, sinNext} = {rotPkg::coef'(851),   rotPkg::coef'(-569)};
         30: {cosNext, sinNext} = {rotPkg::coef'(946),   rotPkg::coef'(-392)};
         31: {cosNext, sinNext} = {rotPkg::coef'(1004),  rotPkg::coef'(-200)};
         default: {cosNext, sinNext} = '0;
      endcase
   end

   // One cycle of lookup latency
   always_ff @(posedge clk) begin
      if (reset) begin
         cosVal <= '0;
         sinVal <= '0;
      end else begin
         cosVal <= cosNext;
         sinVal <= sinNext;
      end
   end

endmodule

//--- logic/cplxMult.sv
// Two-stage pipelined complex multiplier with half-scale truncated output
`timescale 1ns/10ps

module cplxMult (
   input  logic          clk,
   input  logic          reset,
   input  rotPkg::sample i,
   input  rotPkg::sample q,
   input  rotPkg::coef   cosVal,
   input  rotPkg::coef   sinVal,
   output rotPkg::sample iOut,
   output rotPkg::sample qOut
);

   // Full-precision products, sample width plus coef width
   logic signed [rotPkg::ROT_BITS+rotPkg::COEF_BITS-1:0] ixC, qxS, ixS, qxC;
   // One guard bit for the add and subtract
   logic signed [rotPkg::ROT_BITS+rotPkg::COEF_BITS:0]   reSum, imSum;

   // --------------------
   // Stage 1, products
   // --------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         ixC <= '0;
         qxS <= '0;
         ixS <= '0;
         qxC <= '0;
      end else begin
         ixC <= i * cosVal;   // Signed x signed
         qxS <= q * sinVal;
         ixS <= i * sinVal;
         qxC <= q * cosVal;
      end
   end

   assign reSum = ixC - qxS;   // Real part
   assign imSum = ixS + qxC;   // Imag part

   // --------------------
   // Stage 2, combine and scale
   // --------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         iOut <= '0;
         qOut <= '0;
      end else begin
         // Arithmetic shift floors, then keep the low ROT_BITS
         iOut <= rotPkg::sample'(reSum >>> rotPkg::PROD_SHIFT);
         qOut <= rotPkg::sample'(imSum >>> rotPkg::PROD_SHIFT);
      end
   end

endmodule

//--- logic/phaseRotator.sv
// Phase rotator built from coefficient table, sample alignment and complex multiply
`timescale 1ns/10ps

module phaseRotator (
   input  logic            clk,
   input  logic            reset,
   input  rotPkg::sample   i,
   input  rotPkg::sample   q,
   input  rotPkg::phaseIdx angle,
   output rotPkg::sample   iOut,
   output rotPkg::sample   qOut
);

   rotPkg::coef   cosVal, sinVal;   // Valid one cycle after angle
   rotPkg::iqPair iqIn;
   rotPkg::iqPair iqAligned;        // Sample pair lined up with its coefs

   assign iqIn.i = i;
   assign iqIn.q = q;

   // Angle to cos/sin, 1 cycle
   phaseCoefRom coefRom_i (
      .clk    (clk),
      .reset  (reset),
      .angle  (angle),
      .cosVal (cosVal),
      .sinVal (sinVal)
   );

   // Hold the sample while the table answers
   delayLine #(
      .payloadT (rotPkg::iqPair),
      .DEPTH    (1)
   ) iqDelay_i (
      .clk   (clk),
      .reset (reset),
      .din   (iqIn),
      .dout  (iqAligned)
   );

   // Two more cycles, total latency ROT_LATENCY
   cplxMult mult_i (
      .clk    (clk),
      .reset  (reset),
      .i      (iqAligned.i),
      .q      (iqAligned.q),
      .cosVal (cosVal),
      .sinVal (sinVal),
      .iOut   (iOut),
      .qOut   (qOut)
   );

endmodule

//--- logic/multiHPhaseAcc.sv
// Multi-h carrier phase accumulator alternating between two index steps
`timescale 1ns/10ps

module multiHPhaseAcc (
   input  logic            clk,
   input  logic            reset,
   input  logic            symEn,    // One pulse per symbol
   input  rotPkg::phaseIdx hStep0,   // Step for even symbols
   input  rotPkg::phaseIdx hStep1,   // Step for odd symbols
   output rotPkg::phaseIdx phase
);

   logic hSel;   // Which modulation index applies to the next symbol

   rotPkg::phaseIdx step;

   assign step = hSel ? hStep1 : hStep0;

   // Advance once per symbol, otherwise hold
   always_ff @(posedge clk) begin
      if (reset) begin
         phase <= '0;
         hSel  <= 1'b0;
      end else if (symEn) begin
         // Natural wrap of the index is the mod 2pi
         phase <= rotPkg::phaseIdx'(phase + step);
         hSel  <= ~hSel;                           // Swap index every symbol
      end
   end

endmodule

//--- logic/rotatorTop.sv
// Top level joining phase accumulator, rotator and control delay
`timescale 1ns/10ps

module rotatorTop (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        symEn,
   input  logic                        sym2xEn,
   input  logic [rotPkg::SEL_BITS-1:0] sel,
   input  rotPkg::sample               i,
   input  rotPkg::sample               q,
   input  rotPkg::phaseIdx             hStep0,
   input  rotPkg::phaseIdx             hStep1,
   output logic                        symEnOut,
   output logic                        sym2xEnOut,
   output logic [rotPkg::SEL_BITS-1:0] selOut,
   output rotPkg::sample               iOut,
   output rotPkg::sample               qOut,
   output rotPkg::phaseIdx             phase
);

   rotPkg::ctrlBundle ctrlIn, ctrlOut;

   // Phase seen by a sample is the value before its own symEn update
   multiHPhaseAcc phaseAcc_i (
      .clk    (clk),
      .reset  (reset),
      .symEn  (symEn),
      .hStep0 (hStep0),
      .hStep1 (hStep1),
      .phase  (phase)
   );

   phaseRotator rotator_i (
      .clk   (clk),
      .reset (reset),
      .i     (i),
      .q     (q),
      .angle (phase),
      .iOut  (iOut),
      .qOut  (qOut)
   );

   // Strobes and select follow the data through the same latency
   assign ctrlIn.symEn   = symEn;
   assign ctrlIn.sym2xEn = sym2xEn;
   assign ctrlIn.sel     = sel;

   delayLine #(
      .payloadT (rotPkg::ctrlBundle),
      .DEPTH    (rotPkg::ROT_LATENCY)
   ) ctrlDelay_i (
      .clk   (clk),
      .reset (reset),
      .din   (ctrlIn),
      .dout  (ctrlOut)
   );

   assign symEnOut   = ctrlOut.symEn;
   assign sym2xEnOut = ctrlOut.sym2xEn;
   assign selOut     = ctrlOut.sel;

endmodule

//--- test/rotatorTop_checker.sv
// Concurrent assertions on rotatorTop control delay, phase steps and reset state
`timescale 1ns/10ps

module rotatorTop_checker (
   input logic                        clk,
   input logic                        reset,
   input logic                        symEn,
   input logic                        sym2xEn,
   input logic [rotPkg::SEL_BITS-1:0] sel,
   input logic                        symEnOut,
   input logic                        sym2xEnOut,
   input logic [rotPkg::SEL_BITS-1:0] selOut,
   input rotPkg::sample               iOut,
   input rotPkg::sample               qOut,
   input rotPkg::phaseIdx             phase
);

   // --------------------
   // Control delay
   // --------------------
   ctrlDelay : assert property (@(posedge clk)
      !$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3) |->
         symEnOut == $past(symEn, 3) && sym2xEnOut == $past(sym2xEn, 3) &&
         selOut == $past(sel, 3))
      else $error("Control outputs not equal to inputs three cycles earlier");

   // Phase holds unless a symbol strobe came the cycle before
   phaseHold : assert property (@(posedge clk)
      !$past(reset) && !$past(symEn) |-> $stable(phase))
      else $error("Phase moved without a symbol strobe");

   // --------------------
   // Reset state
   // --------------------
   resetZero : assert property (@(posedge clk)
      $past(reset) |-> iOut == '0 && qOut == '0 && selOut == '0 && phase == '0 &&
         !symEnOut && !sym2xEnOut)
      else $error("Outputs not cleared in the cycle after reset");

endmodule

bind rotatorTop rotatorTop_checker checker_i (
   .clk        (clk),
   .reset      (reset),
   .symEn      (symEn),
   .sym2xEn    (sym2xEn),
   .sel        (sel),
   .symEnOut   (symEnOut),
   .sym2xEnOut (sym2xEnOut),
   .selOut     (selOut),
   .iOut       (iOut),
   .qOut       (qOut),
   .phase      (phase)
);

//--- test/rotatorTop_tb.sv
// Testbench for rotatorTop with stimulus table, random phase run and reference model
`timescale 1ns/10ps

module rotatorTop_tb;

   localparam int  NUM_ROWS       = 12;
   localparam int  RAND_CYCLES    = 1600;    // Enough symbols at one per 4 cycles to hit all phases
   localparam int  TIMEOUT_CYCLES = 2 * (NUM_ROWS + RAND_CYCLES) + 20;
   localparam real PI             = 3.14159265358979;

   // iExp and qExp only count when hasExp is set
   typedef struct packed {
      int iIn;
      int qIn;
      bit se;
      bit s2;
      int sl;
      int h0;
      int h1;
      int phExp;      // Phase present when the row is driven
      bit hasExp;
      int iExp;
      int qExp;
   } rowT;

   // What the outputs should show three cycles later
   typedef struct packed {
      rotPkg::sample     iExp;
      rotPkg::sample     qExp;
      rotPkg::ctrlBundle ctrl;
   } expEntry;

   logic                        clk = 1'b0;
   logic                        reset;
   logic                        symEn, sym2xEn;
   logic [rotPkg::SEL_BITS-1:0] sel;
   rotPkg::sample               i, q;
   rotPkg::phaseIdx             hStep0, hStep1;
   logic                        symEnOut, sym2xEnOut;
   logic [rotPkg::SEL_BITS-1:0] selOut;
   rotPkg::sample               iOut, qOut;
   rotPkg::phaseIdx             phase;

   expEntry         expQ [$];       // Reference pipeline
   rotPkg::phaseIdx modelPhase;
   bit              modelHSel;      // Model's modulation index select
   logic [31:0]     coveredPhases;  // One bit per phase seen by a sample
   logic [31:0]     rng;
   int              cycleCount = 0;

   // Steps 3 then 5 give phases 0, 3, 8, 11, 16
   rowT stimTable [NUM_ROWS] = '{
      '{ 1000,  -600, 0, 0,  1, 3, 5,  0, 1,   500,  -300},   // Phase 0 halves
      '{-2048,  2047, 0, 1,  2, 3, 5,  0, 1, -1024,  1023},   // Extremes
      '{ 2047, -2048, 0, 0,  3, 3, 5,  0, 1,  1023, -1024},
      '{   -7,     5, 0, 1,  4, 3, 5,  0, 1,    -4,     2},   // Floor on odd values
      '{  100,   200, 1, 1,  5, 3, 5,  0, 1,    50,   100},   // First symbol steps by 3
      '{  300,  -300, 0, 0,  6, 3, 5,  3, 0,     0,     0},
      '{ -500,   250, 1, 1,  7, 3, 5,  3, 0,     0,     0},   // Step 5 lands on pi/2
      '{-2048,  2047, 0, 0,  8, 3, 5,  8, 1, -1024, -1024},
      '{ 2047, -2048, 0, 1,  9, 3, 5,  8, 1,  1024,  1023},
      '{   -3,     7, 1, 0, 10, 3, 5,  8, 1,    -4,    -2},
      '{  640,  -320, 1, 1, 11, 3, 5, 11, 0,     0,     0},
      '{  600,  -401, 0, 0, 31, 3, 5, 16, 1,  -300,   200}    // Pi negates both
   };

   rotatorTop dut_i (
      .clk        (clk),
      .reset      (reset),
      .symEn      (symEn),
      .sym2xEn    (sym2xEn),
      .sel        (sel),
      .i          (i),
      .q          (q),
      .hStep0     (hStep0),
      .hStep1     (hStep1),
      .symEnOut   (symEnOut),
      .sym2xEnOut (sym2xEnOut),
      .selOut     (selOut),
      .iOut       (iOut),
      .qOut       (qOut),
      .phase      (phase)
   );

   always #10 clk = ~clk;   // 20 ns period

   // --------------------
   // Reference arithmetic
   // --------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic int roundNearest(input real x);
      if (x >= 0.0) return $rtoi(x + 0.5);
      else return -$rtoi(0.5 - x);   // Symmetric about zero
   endfunction

   function automatic int roundedCos(input int k);
      return roundNearest($cos(2.0 * PI * real'(k) / 32.0) * 1024.0);
   endfunction

   function automatic int roundedSin(input int k);
      return roundNearest($sin(2.0 * PI * real'(k) / 32.0) * 1024.0);
   endfunction

   function automatic rotPkg::sample rotatedI(input int iv, input int qv, input int k);
      int prod;
      prod = iv * roundedCos(k) - qv * roundedSin(k);
      return rotPkg::sample'(prod >>> rotPkg::PROD_SHIFT);   // Floor
   endfunction

   function automatic rotPkg::sample rotatedQ(input int iv, input int qv, input int k);
      int prod;
      prod = iv * roundedSin(k) + qv * roundedCos(k);
      return rotPkg::sample'(prod >>> rotPkg::PROD_SHIFT);
   endfunction

   // --------------------
   // Compare and stop
   // --------------------
   task automatic stopFailed(input string why);
      $display("TESTS FAILED");
      $fatal(1, why);
   endtask

   task automatic checkSample(input rotPkg::sample got, input rotPkg::sample exp,
                              input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
         stopFailed("sample value wrong");
      end
   endtask

   task automatic checkPhase(input rotPkg::phaseIdx got, input rotPkg::phaseIdx exp,
                             input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
         stopFailed("phase value wrong");
      end
   endtask

   task automatic checkCtrl(input rotPkg::ctrlBundle got, input rotPkg::ctrlBundle exp,
                            input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got symEn=%0b sym2xEn=%0b sel=%0d", $time, what,
                  got.symEn, got.sym2xEn, got.sel);
         $display("   expected symEn=%0b sym2xEn=%0b sel=%0d", exp.symEn, exp.sym2xEn,
                  exp.sel);
         stopFailed("control value wrong");
      end
   endtask

   // One clock of checks, then the next inputs and their model
   task automatic applyCycle(input int iIn, input int qIn, input bit se, input bit s2,
                             input int sl, input int h0, input int h1, input int phExp,
                             input bit hasExp, input int iTab, input int qTab);
      expEntry due;
      expEntry nxt;
      @(posedge clk);
      #2;
      checkPhase(phase, modelPhase, "accumulator phase");
      if (phExp >= 0) checkPhase(phase, rotPkg::phaseIdx'(phExp), "table phase");
      if (expQ.size() >= rotPkg::ROT_LATENCY) begin
         due = expQ.pop_front();
         checkSample(iOut, due.iExp, "iOut");
         checkSample(qOut, due.qExp, "qOut");
         checkCtrl(rotPkg::ctrlBundle'({symEnOut, sym2xEnOut, selOut}), due.ctrl, "control");
      end
      i       = rotPkg::sample'(iIn);
      q       = rotPkg::sample'(qIn);
      symEn   = se;
      sym2xEn = s2;
      sel     = sl[rotPkg::SEL_BITS-1:0];
      hStep0  = rotPkg::phaseIdx'(h0);
      hStep1  = rotPkg::phaseIdx'(h1);
      // Sample sees the phase before its own symbol update
      nxt.iExp         = hasExp ? rotPkg::sample'(iTab) : rotatedI(iIn, qIn, modelPhase);
      nxt.qExp         = hasExp ? rotPkg::sample'(qTab) : rotatedQ(iIn, qIn, modelPhase);
      nxt.ctrl.symEn   = se;
      nxt.ctrl.sym2xEn = s2;
      nxt.ctrl.sel     = sl[rotPkg::SEL_BITS-1:0];
      expQ.push_back(nxt);
      coveredPhases[modelPhase] = 1'b1;
      if (se) begin
         modelPhase = rotPkg::phaseIdx'(modelPhase + (modelHSel ? h1 : h0));   // Mod 32
         modelHSel  = ~modelHSel;
      end
   endtask

   // --------------------
   // Main sequence
   // --------------------
   initial begin
      int iv, qv, sl, curH0, curH1;
      reset         = 1'b1;
      symEn         = 1'b0;
      sym2xEn       = 1'b0;
      sel           = '0;
      i             = '0;
      q             = '0;
      hStep0        = '0;
      hStep1        = '0;
      rng           = 32'h4153_1fdd;
      modelPhase    = '0;
      modelHSel     = 1'b0;
      coveredPhases = '0;
      curH0         = 0;
      curH1         = 0;
      repeat (3) @(posedge clk);
      #2;
      // Everything flushed by reset
      checkSample(iOut, '0, "iOut after reset");
      checkSample(qOut, '0, "qOut after reset");
      checkCtrl(rotPkg::ctrlBundle'({symEnOut, sym2xEnOut, selOut}), '0, "control after reset");
      checkPhase(phase, '0, "phase after reset");
      reset = 1'b0;
      repeat (rotPkg::ROT_LATENCY) expQ.push_back('0);   // Zeros still in the pipe

      for (int r = 0; r < NUM_ROWS; r++) begin
         applyCycle(stimTable[r].iIn, stimTable[r].qIn, stimTable[r].se, stimTable[r].s2,
                    stimTable[r].sl, stimTable[r].h0, stimTable[r].h1, stimTable[r].phExp,
                    stimTable[r].hasExp, stimTable[r].iExp, stimTable[r].qExp);
      end

      // Random samples and step pairs
      for (int k = 0; k < RAND_CYCLES; k++) begin
         rng = xorshift32(rng);
         iv  = $signed(rng[11:0]);
         qv  = $signed(rng[23:12]);
         sl  = rng[28:24];
         if (modelPhase == 5'd4) begin   // Full scale corners at pi/4
            iv = rng[30] ? -2048 : 2047;
            qv = rng[31] ? -2048 : 2047;
         end
         if (k % 4 == 0) begin
            rng   = xorshift32(rng);
            curH0 = rng[4:0];
            curH1 = rng[9:5];
         end
         applyCycle(iv, qv, k % 4 == 0, k % 2 == 0, sl, curH0, curH1, -1, 1'b0, 0, 0);
      end

      repeat (rotPkg::ROT_LATENCY) applyCycle(0, 0, 1'b0, 1'b0, 0, 0, 0, -1, 1'b0, 0, 0);

      if (coveredPhases == 32'hFFFF_FFFF) begin
         $display("TESTS PASSED");
         $finish;
      end else begin
         $display("Random run did not reach every one of the 32 phases (mask %h)",
                  coveredPhases);
         stopFailed("phase coverage incomplete");
      end
   end

   // Run length guard
   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, the test sequence did not finish", cycleCount);
         stopFailed("timeout");
      end
   end

endmodule

//--- rotatorTop.f
logic/rotPkg.sv
logic/delayLine.sv
logic/phaseCoefRom.sv
logic/cplxMult.sv
logic/phaseRotator.sv
logic/multiHPhaseAcc.sv
logic/rotatorTop.sv
test/rotatorTop_checker.sv
test/rotatorTop_tb.sv

//--- Makefile
# Verilator build, run and lint for the phase rotator

VERILATOR  ?= verilator
TOP        ?= rotatorTop_tb
FILELIST   ?= rotatorTop.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= TESTS PASSED
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the exit code
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
